// ==== verilog/adder_pkg.sv ====
package adder_pkg;

    // Processor datapath widths
    localparam int DATA_W   = 8;
    localparam int ADDR_W   = 12;
    localparam int INSTR_W  = 18;

    // Instruction fields, opcode on top, then destination register
    localparam int OPCODE_W = 5;
    localparam int REG_W    = 4;
    localparam int NUM_REGS = 1 << REG_W;

    // Bit positions of the opcode and destination fields
    localparam int OPCODE_LSB = INSTR_W - OPCODE_W;
    localparam int DST_LSB    = OPCODE_LSB - REG_W;

    // Low byte carries a constant or port number, low nibble a source register
    // Jumps take their target from the low ADDR_W bits
    typedef enum logic [OPCODE_W-1:0] {
        LOAD_K,
        INPUT,
        OUTPUT,
        ADD,
        ADDCY,
        AND_K,
        JUMP,
        JUMP_Z,
        JUMP_NZ
    } opcode_t;

    // Two-phase instruction cycle
    typedef enum logic {
        FETCH,
        EXECUTE
    } cpu_state_t;

    // I/O port map
    localparam logic [DATA_W-1:0] PORT_START  = 8'h00;
    localparam logic [DATA_W-1:0] PORT_INCR   = 8'h01;
    localparam logic [DATA_W-1:0] PORT_SUM_LO = 8'h02;
    // Write to the high byte commits the whole sum
    localparam logic [DATA_W-1:0] PORT_SUM_HI = 8'h03;
    // Bit 0 is the display hold done flag
    localparam logic [DATA_W-1:0] PORT_STATUS = 8'h04;

endpackage

// ==== verilog/io_bus_if.sv ====
`timescale 1ns/1ps

interface io_bus_if;

    // Port address, valid while either strobe is high
    logic [adder_pkg::DATA_W-1:0] port_id;
    // Write data from the processor
    logic [adder_pkg::DATA_W-1:0] out_port;
    // Read data back to the processor
    logic [adder_pkg::DATA_W-1:0] in_port;
    // Single-cycle strobes during EXECUTE
    logic write_strobe;
    logic read_strobe;

    modport cpu (
        output port_id, out_port, write_strobe, read_strobe,
        input  in_port
    );

    modport periph (
        input  port_id, out_port, write_strobe, read_strobe,
        output in_port
    );

endinterface

// ==== verilog/mini_cpu.sv ====
`timescale 1ns/1ps

module mini_cpu (
    input  logic                             clk,
    input  logic                             reset,
    output logic [adder_pkg::ADDR_W-1:0]     address,
    input  logic [adder_pkg::INSTR_W-1:0]    instruction,
    io_bus_if.cpu                            bus
);

    // Control state
    adder_pkg::cpu_state_t state;
    logic [adder_pkg::ADDR_W-1:0] pc;
    logic zero;
    logic carry;

    // Latched instruction and register file
    logic [adder_pkg::INSTR_W-1:0] ir;
    logic [adder_pkg::DATA_W-1:0] regs [adder_pkg::NUM_REGS];

    // Decoded fields
    adder_pkg::opcode_t op;
    logic [adder_pkg::REG_W-1:0] dst;
    logic [adder_pkg::REG_W-1:0] src;
    logic [adder_pkg::DATA_W-1:0] imm;
    logic [adder_pkg::ADDR_W-1:0] target;
    logic [adder_pkg::DATA_W-1:0] dst_val;
    logic [adder_pkg::DATA_W-1:0] src_val;

    // Execute results
    logic [adder_pkg::DATA_W-1:0] result;
    logic result_carry;
    logic reg_we;
    logic flag_we;
    logic jump_taken;
    logic executing;

    assign op        = adder_pkg::opcode_t'(ir[adder_pkg::OPCODE_LSB +: adder_pkg::OPCODE_W]);
    assign dst       = ir[adder_pkg::DST_LSB +: adder_pkg::REG_W];
    assign src       = ir[adder_pkg::REG_W-1:0];
    assign imm       = ir[adder_pkg::DATA_W-1:0];
    assign target    = ir[adder_pkg::ADDR_W-1:0];
    assign dst_val   = regs[dst];
    assign src_val   = regs[src];
    assign executing = (state == adder_pkg::EXECUTE);

    // Program counter drives the ROM directly
    assign address = pc;

    // Port number comes from the constant field, data from the destination register
    assign bus.port_id      = imm;
    assign bus.out_port     = dst_val;
    assign bus.write_strobe = executing && (op == adder_pkg::OUTPUT);
    assign bus.read_strobe  = executing && (op == adder_pkg::INPUT);

    // ALU and branch decision
    always_comb begin
        result       = '0;
        result_carry = 1'b0;
        reg_we       = 1'b0;
        flag_we      = 1'b0;
        jump_taken   = 1'b0;
        case (op)
            adder_pkg::LOAD_K: begin
                result = imm;
                reg_we = 1'b1;
            end
            adder_pkg::INPUT: begin
                // Sampled on the edge that ends the read strobe
                result = bus.in_port;
                reg_we = 1'b1;
            end
            adder_pkg::ADD: begin
                {result_carry, result} = {1'b0, dst_val} + {1'b0, src_val};
                reg_we  = 1'b1;
                flag_we = 1'b1;
            end
            adder_pkg::ADDCY: begin
                // Carry in from the previous add
                {result_carry, result} = {1'b0, dst_val} + {1'b0, src_val} + carry;
                reg_we  = 1'b1;
                flag_we = 1'b1;
            end
            adder_pkg::AND_K: begin
                // Carry always clears here
                result  = dst_val & imm;
                reg_we  = 1'b1;
                flag_we = 1'b1;
            end
            adder_pkg::JUMP:    jump_taken = 1'b1;
            adder_pkg::JUMP_Z:  jump_taken = zero;
            adder_pkg::JUMP_NZ: jump_taken = !zero;
            default: begin
                result = '0;
            end
        endcase
    end

    // Fetch/execute FSM, flags and program counter
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= adder_pkg::FETCH;
            pc    <= '0;
            zero  <= 1'b0;
            carry <= 1'b0;
        end else begin
            case (state)
                adder_pkg::FETCH: begin
                    state <= adder_pkg::EXECUTE;
                end
                default: begin
                    state <= adder_pkg::FETCH;
                    pc    <= jump_taken ? target : pc + 1'b1;
                    if (flag_we) begin
                        zero  <= (result == '0);
                        carry <= result_carry;
                    end
                end
            endcase
        end
    end

    // Instruction latch
    always_ff @(posedge clk) begin
        if (state == adder_pkg::FETCH) begin
            ir <= instruction;
        end
    end

    // Register file write port
    always_ff @(posedge clk) begin
        if (executing && reg_we) begin
            regs[dst] <= result;
        end
    end

endmodule

// ==== verilog/program_rom.sv ====
`timescale 1ns/1ps

module program_rom (
    input  logic [adder_pkg::ADDR_W-1:0]  address,
    output logic [adder_pkg::INSTR_W-1:0] instruction
);

    // Register allocation
    localparam logic [adder_pkg::REG_W-1:0] R_SUM_LO = 4'd0;
    localparam logic [adder_pkg::REG_W-1:0] R_INCR   = 4'd1;
    localparam logic [adder_pkg::REG_W-1:0] R_SUM_HI = 4'd2;
    localparam logic [adder_pkg::REG_W-1:0] R_ZERO   = 4'd3;
    localparam logic [adder_pkg::REG_W-1:0] R_STAT   = 4'd4;

    // Branch targets
    localparam logic [adder_pkg::ADDR_W-1:0] LOOP_ADDR = 12'd4;
    localparam logic [adder_pkg::ADDR_W-1:0] POLL_ADDR = 12'd6;

    // Register and constant form
    function automatic logic [adder_pkg::INSTR_W-1:0] op_k(
        adder_pkg::opcode_t op, logic [adder_pkg::REG_W-1:0] dst,
        logic [adder_pkg::DATA_W-1:0] k);
        return {op, dst, {(adder_pkg::DST_LSB - adder_pkg::DATA_W){1'b0}}, k};
    endfunction

    // Register and register form
    function automatic logic [adder_pkg::INSTR_W-1:0] op_r(
        adder_pkg::opcode_t op, logic [adder_pkg::REG_W-1:0] dst,
        logic [adder_pkg::REG_W-1:0] src);
        return {op, dst, {(adder_pkg::DST_LSB - adder_pkg::REG_W){1'b0}}, src};
    endfunction

    // Jump form
    function automatic logic [adder_pkg::INSTR_W-1:0] op_j(
        adder_pkg::opcode_t op, logic [adder_pkg::ADDR_W-1:0] dest);
        return {op, {(adder_pkg::OPCODE_LSB - adder_pkg::ADDR_W){1'b0}}, dest};
    endfunction

    always_comb begin
        case (address)
            12'd0:  instruction = op_k(adder_pkg::INPUT, R_SUM_LO, adder_pkg::PORT_START);
            12'd1:  instruction = op_k(adder_pkg::INPUT, R_INCR, adder_pkg::PORT_INCR);
            12'd2:  instruction = op_k(adder_pkg::LOAD_K, R_SUM_HI, 8'h00);
            12'd3:  instruction = op_k(adder_pkg::LOAD_K, R_ZERO, 8'h00);
            // Loop: publish low byte, then commit with the high byte
            12'd4:  instruction = op_k(adder_pkg::OUTPUT, R_SUM_LO, adder_pkg::PORT_SUM_LO);
            12'd5:  instruction = op_k(adder_pkg::OUTPUT, R_SUM_HI, adder_pkg::PORT_SUM_HI);
            // Spin until the display hold time has elapsed
            12'd6:  instruction = op_k(adder_pkg::INPUT, R_STAT, adder_pkg::PORT_STATUS);
            12'd7:  instruction = op_k(adder_pkg::AND_K, R_STAT, 8'h01);
            12'd8:  instruction = op_j(adder_pkg::JUMP_Z, POLL_ADDR);
            // 16-bit accumulate with carry into the high byte
            12'd9:  instruction = op_r(adder_pkg::ADD, R_SUM_LO, R_INCR);
            12'd10: instruction = op_r(adder_pkg::ADDCY, R_SUM_HI, R_ZERO);
            12'd11: instruction = op_j(adder_pkg::JUMP, LOOP_ADDR);
            default: instruction = op_j(adder_pkg::JUMP, '0);
        endcase
    end

endmodule

// ==== verilog/binary_to_bcd.sv ====
`timescale 1ns/1ps

module binary_to_bcd (
    input  logic [15:0] binary,
    output logic [19:0] bcd
);

    localparam int BIN_W  = 16;
    localparam int DIGITS = 5;
    localparam int BCD_W  = 4 * DIGITS;

    // BCD field on top, binary shifted out of the bottom
    logic [BCD_W+BIN_W-1:0] scratch;

    // Shift-and-add-three, one pass per input bit
    always_comb begin
        scratch = {{BCD_W{1'b0}}, binary};
        for (int i = 0; i < BIN_W; i++) begin
            // Pre-correct every digit that would overflow when doubled
            for (int d = 0; d < DIGITS; d++) begin
                if (scratch[BIN_W + 4*d +: 4] >= 4'd5) begin
                    scratch[BIN_W + 4*d +: 4] = scratch[BIN_W + 4*d +: 4] + 4'd3;
                end
            end
            scratch = scratch << 1;
        end
        bcd = scratch[BCD_W+BIN_W-1:BIN_W];
    end

endmodule

// ==== verilog/segment_display.sv ====
`timescale 1ns/1ps

module segment_display #(
    parameter int HOLD_CYCLES = 100_000_000,
    parameter int SCAN_CYCLES = 100_000
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [15:0] digits,
    input  logic        commit,
    output logic [6:0]  seg,
    output logic [3:0]  an,
    output logic        done
);

    localparam int HOLD_W = $clog2(HOLD_CYCLES + 1);
    localparam int SCAN_W = $clog2(SCAN_CYCLES + 1);

    // Digits being shown, captured on commit
    logic [15:0] shown;
    // Set by the first commit, keeps the display dark before that
    logic active;
    logic [SCAN_W-1:0] scan_count;
    logic [1:0] digit_sel;
    logic [HOLD_W-1:0] hold_count;
    logic [3:0] cur_digit;

    always_ff @(posedge clk) begin
        if (commit) begin
            shown <= digits;
        end
    end

    // Anode scan, one step every SCAN_CYCLES clocks
    always_ff @(posedge clk) begin
        if (reset) begin
            active     <= 1'b0;
            scan_count <= '0;
            digit_sel  <= '0;
        end else begin
            if (commit) begin
                active <= 1'b1;
            end
            if (scan_count == SCAN_W'(SCAN_CYCLES - 1)) begin
                scan_count <= '0;
                digit_sel  <= digit_sel + 1'b1;
            end else begin
                scan_count <= scan_count + 1'b1;
            end
        end
    end

    // Hold timer
    // Commit reloads it and drops done, done rises HOLD_CYCLES after commit
    always_ff @(posedge clk) begin
        if (reset) begin
            hold_count <= '0;
            done       <= 1'b0;
        end else if (commit) begin
            hold_count <= HOLD_W'(HOLD_CYCLES - 1);
            done       <= 1'b0;
        end else if (hold_count != '0) begin
            if (hold_count == HOLD_W'(1)) begin
                done <= 1'b1;
            end
            hold_count <= hold_count - 1'b1;
        end
    end

    // Digit 0 is the ones digit on the rightmost anode
    assign cur_digit = shown[4*digit_sel +: 4];

    // Active-low anodes and segments, ordered a..g from the MSB
    always_comb begin
        an = active ? ~(4'b0001 << digit_sel) : 4'b1111;
        if (!active) begin
            seg = 7'b1111111;
        end else begin
            case (cur_digit)
                4'd0: seg = 7'b0000001;
                4'd1: seg = 7'b1001111;
                4'd2: seg = 7'b0010010;
                4'd3: seg = 7'b0000110;
                4'd4: seg = 7'b1001100;
                4'd5: seg = 7'b0100100;
                4'd6: seg = 7'b0100000;
                4'd7: seg = 7'b0001111;
                4'd8: seg = 7'b0000000;
                4'd9: seg = 7'b0000100;
                // Non-BCD codes show blank
                default: seg = 7'b1111111;
            endcase
        end
    end

endmodule

// ==== verilog/adder_display_top.sv ====
`timescale 1ns/1ps

module adder_display_top #(
    parameter int HOLD_CYCLES = 100_000_000,
    parameter int SCAN_CYCLES = 100_000
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [15:0] sw,
    output logic [6:0]  seg,
    output logic [3:0]  an,
    output logic [15:0] led
);

    // Instruction fetch path
    logic [adder_pkg::ADDR_W-1:0]  address;
    logic [adder_pkg::INSTR_W-1:0] instruction;

    // Sum staging and commit
    logic [adder_pkg::DATA_W-1:0] sum_lo_stage;
    logic [15:0] sum;
    logic lo_write;
    logic hi_write;
    logic commit;

    // Display path
    logic [19:0] bcd;
    logic done;

    io_bus_if bus ();

    mini_cpu u_cpu (
        .clk         (clk),
        .reset       (reset),
        .address     (address),
        .instruction (instruction),
        .bus         (bus.cpu)
    );

    program_rom u_rom (
        .address     (address),
        .instruction (instruction)
    );

    // Peripheral side of the bus, write decode
    assign lo_write = bus.write_strobe && (bus.port_id == adder_pkg::PORT_SUM_LO);
    assign hi_write = bus.write_strobe && (bus.port_id == adder_pkg::PORT_SUM_HI);

    // Read mux
    always_comb begin
        case (bus.port_id)
            adder_pkg::PORT_START:  bus.in_port = sw[7:0];
            adder_pkg::PORT_INCR:   bus.in_port = sw[15:8];
            adder_pkg::PORT_STATUS: bus.in_port = {7'd0, done};
            default:                bus.in_port = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (lo_write) begin
            sum_lo_stage <= bus.out_port;
        end
    end

    // High byte write commits both bytes at once
    always_ff @(posedge clk) begin
        if (reset) begin
            sum    <= '0;
            commit <= 1'b0;
        end else begin
            commit <= hi_write;
            if (hi_write) begin
                sum <= {bus.out_port, sum_lo_stage};
            end
        end
    end

    assign led = sum;

    binary_to_bcd u_bcd (
        .binary (sum),
        .bcd    (bcd)
    );

    // Only the low four decimal digits fit the display
    segment_display #(
        .HOLD_CYCLES (HOLD_CYCLES),
        .SCAN_CYCLES (SCAN_CYCLES)
    ) u_display (
        .clk    (clk),
        .reset  (reset),
        .digits (bcd[15:0]),
        .commit (commit),
        .seg    (seg),
        .an     (an),
        .done   (done)
    );

endmodule

// ==== bench/tb_adder_display.sv ====
`timescale 1ns/1ps

module tb_adder_display;

    localparam int HOLD_CYCLES  = 200;
    localparam int SCAN_CYCLES  = 8;
    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 8;

    // Update counts per test, random tests run three times
    localparam int FIRST_UPDATES  = 1;
    localparam int SEQ_UPDATES    = 16;
    localparam int WRAP_UPDATES   = 260;
    localparam int SWITCH_UPDATES = 8;
    localparam int RAND_UPDATES   = 5;
    localparam int RAND_TESTS     = 3;
    localparam int NUM_TESTS      = 4 + RAND_TESTS;
    localparam int TOTAL_UPDATES  = FIRST_UPDATES + SEQ_UPDATES + WRAP_UPDATES
                                    + SWITCH_UPDATES + RAND_TESTS * RAND_UPDATES;

    // Twice the hold time per update, plus every reset and some slack
    localparam longint TIMEOUT_CYCLES = longint'(TOTAL_UPDATES) * 2 * HOLD_CYCLES
                                        + NUM_TESTS * (RESET_CYCLES + 4) + 2000;

    logic        clk;
    logic        reset;
    logic [15:0] sw;
    logic [6:0]  seg;
    logic [3:0]  an;
    logic [15:0] led;

    // Reference inputs of the running test
    logic [7:0]  ref_start;
    logic [7:0]  ref_incr;
    logic [15:0] prev_led;
    int          update_count;
    int          error_count;
    int          tests_run;
    int          tests_failed;
    int          cycle_count = 0;
    int          last_update_cycle;
    integer      seed = 32'h3e;

    adder_display_top #(
        .HOLD_CYCLES (HOLD_CYCLES),
        .SCAN_CYCLES (SCAN_CYCLES)
    ) UUT (
        .clk   (clk),
        .reset (reset),
        .sw    (sw),
        .seg   (seg),
        .an    (an),
        .led   (led)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Free-running cycle count for the update spacing check
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // Running sum after k additions, wraps at 16 bits
    function automatic logic [15:0] expected_sum(logic [7:0] start, logic [7:0] incr, int k);
        int unsigned total;
        total = start + k * incr;
        return 16'(total % 65536);
    endfunction

    // Low four decimal digits, ones digit at the bottom
    function automatic logic [15:0] expected_digits(logic [15:0] sum);
        int unsigned value;
        logic [15:0] digits;
        value = sum % 10000;
        for (int d = 0; d < 4; d++) begin
            digits[4*d +: 4] = 4'(value % 10);
            value = value / 10;
        end
        return digits;
    endfunction

    // Active-low a..g pattern back to a digit, F for anything else
    function automatic logic [3:0] segments_to_digit(logic [6:0] pattern);
        case (pattern)
            7'b0000001: return 4'd0;
            7'b1001111: return 4'd1;
            7'b0010010: return 4'd2;
            7'b0000110: return 4'd3;
            7'b1001100: return 4'd4;
            7'b0100100: return 4'd5;
            7'b0100000: return 4'd6;
            7'b0001111: return 4'd7;
            7'b0000000: return 4'd8;
            7'b0000100: return 4'd9;
            default:    return 4'hf;
        endcase
    endfunction

    task automatic check_sum(string name, logic [15:0] expected, logic [15:0] actual);
        if (actual !== expected) begin
            $display("Mismatch %s expected %h actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_digits(string name, logic [15:0] expected, logic [15:0] actual);
        if (actual !== expected) begin
            $display("Mismatch %s expected %h actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    // Anodes and segments together, both active low
    task automatic check_display(logic [3:0] exp_an, logic [6:0] exp_seg);
        if (an !== exp_an) begin
            $display("Mismatch an expected %h actual %h", exp_an, an);
            error_count++;
        end
        if (seg !== exp_seg) begin
            $display("Mismatch seg expected %h actual %h", exp_seg, seg);
            error_count++;
        end
    endtask

    // Walk the anodes from the rightmost digit and decode each one
    task automatic read_display(output logic [15:0] digits);
        int waited;
        logic [3:0] pattern;
        // Commit pulse loads the new digits one cycle after led
        repeat (2) @(negedge clk);
        digits = '0;
        for (int d = 0; d < 4; d++) begin
            pattern = ~(4'b0001 << d);
            waited = 0;
            while (an !== pattern && waited < 8 * SCAN_CYCLES) begin
                @(negedge clk);
                waited++;
            end
            if (an !== pattern) begin
                $display("Digit %0d was never selected on the anodes", d);
                error_count++;
            end
            digits[4*d +: 4] = segments_to_digit(seg);
        end
    endtask

    // Compare every led change with the reference, then the display
    initial begin : led_monitor
        logic [15:0] seen;
        logic [15:0] expected;
        forever begin
            @(negedge clk);
            if (reset) begin
                prev_led = led;
            end else if (led !== prev_led) begin
                expected = expected_sum(ref_start, ref_incr, update_count);
                check_sum("led", expected, led);
                if (update_count > 0 && cycle_count - last_update_cycle < HOLD_CYCLES) begin
                    $display("Update %0d came only %0d cycles after the one before it",
                             update_count, cycle_count - last_update_cycle);
                    error_count++;
                end
                last_update_cycle = cycle_count;
                prev_led = led;
                read_display(seen);
                check_digits("seg_digits", expected_digits(expected), seen);
                update_count++;
            end
        end
    end

    task automatic wait_updates(int count);
        while (update_count < count) begin
            @(negedge clk);
        end
    endtask

    // Reset, load switches, collect updates, report one line
    task automatic run_test(string name, logic [7:0] start, logic [7:0] incr,
                            int updates, logic swap_switches);
        int errors_before;
        errors_before = error_count;
        tests_run++;
        @(negedge clk);
        reset = 1'b1;
        sw = {incr, start};
        ref_start = start;
        ref_incr = incr;
        update_count = 0;
        repeat (RESET_CYCLES) @(negedge clk);
        // Outputs idle while in reset
        check_sum("led", 16'h0000, led);
        check_display(4'hf, 7'h7f);
        reset = 1'b0;
        @(negedge clk);
        // Still dark before the program commits anything
        check_sum("led", 16'h0000, led);
        check_display(4'hf, 7'h7f);
        wait_updates(1);
        if (swap_switches) begin
            // Program already read the switches, so this must not matter
            sw = 16'($random(seed));
        end
        wait_updates(updates);
        if (error_count == errors_before) begin
            $display("Test %s PASS after %0d updates", name, update_count);
        end else begin
            $display("Test %s FAIL after %0d updates", name, update_count);
            tests_failed++;
        end
    endtask

    initial begin : watchdog
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Timeout, the display stopped updating at update %0d of the current test",
                 update_count);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin : stimulus
        logic [31:0] rand_word;
        logic [7:0]  start;
        logic [7:0]  incr;
        clk = 1'b0;
        reset = 1'b1;
        sw = '0;
        ref_start = '0;
        ref_incr = '0;
        prev_led = '0;
        update_count = 0;
        error_count = 0;
        tests_run = 0;
        tests_failed = 0;
        last_update_cycle = 0;

        run_test("reset_and_first_update", 8'h5a, 8'h07, FIRST_UPDATES, 1'b0);
        // Long enough for the low byte to carry into the high byte
        run_test("sequence_4_plus_20", 8'd4, 8'd20, SEQ_UPDATES, 1'b0);
        run_test("wrap_past_65535", 8'd250, 8'd255, WRAP_UPDATES, 1'b0);
        run_test("switch_change", 8'd9, 8'd3, SWITCH_UPDATES, 1'b1);

        // Zero start or increment would leave led unchanged
        for (int i = 0; i < RAND_TESTS; i++) begin
            rand_word = $random(seed);
            start = rand_word[7:0];
            incr = rand_word[15:8];
            if (start == 8'd0) begin
                start = 8'd1;
            end
            if (incr == 8'd0) begin
                incr = 8'd1;
            end
            run_test($sformatf("random_pair_%0d", i), start, incr, RAND_UPDATES, 1'b1);
        end

        $display("Tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
verilog/adder_pkg.sv
verilog/io_bus_if.sv
verilog/mini_cpu.sv
verilog/program_rom.sv
verilog/binary_to_bcd.sv
verilog/segment_display.sv
verilog/adder_display_top.sv
bench/tb_adder_display.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, result decided from sim.log

cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing -Wno-fatal --top-module tb_adder_display -f sim.f \
    && ./obj_dir/Vtb_adder_display | tee sim.log \
    || { echo "Build or run failed"; exit 1; }

grep -qx "NO ERRORS" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
